// ==== hw/fillq.sv ====
`timescale 1ns/1ps

module fillq #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    parameter int  L1_NUM_SETS     = 16,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             flq_alloc_mm2,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    alloc_addr_mm2,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] alloc_ld_id_mm2,
    input  logic                             flq_done_mm2,
    input  logic [FLQ_ID_SZ-1:0]             done_flq_id_mm2,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    pipe_addr_mm1,
    output logic                             flq_addr_mat_mm2,
    output logic                             flq_full_mm2,
    output logic                             mem_req_valid,
    output logic [l1_fill_pkg::PA_SZ-1:0]    mem_req_addr,
    output logic [FLQ_ID_SZ-1:0]             mem_req_flq_id,
    input  logic                             mem_rsp_valid,
    input  logic [FLQ_ID_SZ-1:0]             mem_rsp_flq_id,
    output logic                             flq_pipe_req,
    output logic [l1_fill_pkg::PA_SZ-1:0]    flq_pipe_addr,
    output logic [FLQ_ID_SZ-1:0]             flq_pipe_flq_id,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] flq_pipe_ld_id,
    input  logic                             flq_pipe_gnt
);

    import l1_fill_pkg::*;

    localparam int SET_HI = LINE_OFS + $clog2(L1_NUM_SETS) - 1;
    localparam int CNT_SZ = FLQ_ID_SZ + 1;

    logic [FLQ_NUM_ENTRIES-1:0] e_valid;
    logic [FLQ_NUM_ENTRIES-1:0] e_mem_req;
    logic [FLQ_NUM_ENTRIES-1:0] e_pipe_req;
    logic [FLQ_NUM_ENTRIES-1:0] e_alloc;
    logic [FLQ_NUM_ENTRIES-1:0] e_done;
    logic [FLQ_NUM_ENTRIES-1:0] e_pipe_gnt;
    logic [FLQ_NUM_ENTRIES-1:0] mem_sel;
    logic [FLQ_NUM_ENTRIES-1:0] pipe_sel;
    logic [PA_SZ-1:0]           e_addr [FLQ_NUM_ENTRIES];
    logic [LD_ID_SZ-1:0]        e_ld_id [FLQ_NUM_ENTRIES];
    logic                       addr_mat_mm1;
    logic [CNT_SZ-1:0]          n_busy_mm1;

    // Lowest set bit, one-hot
    function automatic logic [FLQ_NUM_ENTRIES-1:0] find_first(
        input logic [FLQ_NUM_ENTRIES-1:0] req
    );
        return req & (~req + FLQ_NUM_ENTRIES'(1));
    endfunction

    assign e_alloc    = flq_alloc_mm2 ? find_first(~e_valid) : '0;
    assign mem_sel    = find_first(e_mem_req);
    assign pipe_sel   = find_first(e_pipe_req);
    assign e_pipe_gnt = flq_pipe_gnt ? pipe_sel : '0;

    for (genvar e = 0; e < FLQ_NUM_ENTRIES; e++) begin : g_entry
        assign e_done[e] = flq_done_mm2 && done_flq_id_mm2 == FLQ_ID_SZ'(e);

        fillq_entry #(
            .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES),
            .E_ID            (e)
        ) i_entry (
            .clk,
            .rst_n,
            .alloc          (e_alloc[e]),
            .alloc_addr     (alloc_addr_mm2),
            .alloc_ld_id    (alloc_ld_id_mm2),
            .mem_sel        (mem_sel[e]),
            .mem_rsp_valid,
            .mem_rsp_flq_id,
            .pipe_gnt       (e_pipe_gnt[e]),
            .done           (e_done[e]),
            .e_valid        (e_valid[e]),
            .e_addr         (e_addr[e]),
            .e_ld_id        (e_ld_id[e]),
            .e_mem_req      (e_mem_req[e]),
            .e_pipe_req     (e_pipe_req[e])
        );
    end

    // Memory accepts every request, so selection is the grant
    assign mem_req_valid = |e_mem_req;
    assign flq_pipe_req  = |e_pipe_req;

    always_comb begin
        mem_req_addr    = '0;
        mem_req_flq_id  = '0;
        flq_pipe_addr   = '0;
        flq_pipe_flq_id = '0;
        flq_pipe_ld_id  = '0;
        for (int e = 0; e < FLQ_NUM_ENTRIES; e++) begin
            if (mem_sel[e]) begin
                mem_req_addr   = e_addr[e];
                mem_req_flq_id = FLQ_ID_SZ'(e);
            end
            if (pipe_sel[e]) begin
                flq_pipe_addr   = e_addr[e];
                flq_pipe_flq_id = FLQ_ID_SZ'(e);
                flq_pipe_ld_id  = e_ld_id[e];
            end
        end
    end

    // Set CAM also covers the entry being allocated this cycle
    always_comb begin
        addr_mat_mm1 = flq_alloc_mm2 &&
            alloc_addr_mm2[SET_HI:LINE_OFS] == pipe_addr_mm1[SET_HI:LINE_OFS];
        n_busy_mm1   = CNT_SZ'(flq_alloc_mm2);
        for (int e = 0; e < FLQ_NUM_ENTRIES; e++) begin
            if (e_valid[e] && e_addr[e][SET_HI:LINE_OFS] == pipe_addr_mm1[SET_HI:LINE_OFS]) begin
                addr_mat_mm1 = 1'b1;
            end
            n_busy_mm1 = n_busy_mm1 + CNT_SZ'(e_valid[e]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flq_addr_mat_mm2 <= 1'b0;
            flq_full_mm2     <= 1'b0;
        end else begin
            flq_addr_mat_mm2 <= addr_mat_mm1;
            flq_full_mm2     <= n_busy_mm1 >= CNT_SZ'(FLQ_NUM_ENTRIES);
        end
    end

    for (genvar i = 0; i < FLQ_NUM_ENTRIES; i++) begin : g_uniq_i
        for (genvar j = i + 1; j < FLQ_NUM_ENTRIES; j++) begin : g_uniq_j
            a_uniq_line: assert property (@(posedge clk) disable iff (!rst_n)
                !(e_valid[i] && e_valid[j] &&
                  e_addr[i][PA_SZ-1:LINE_OFS] == e_addr[j][PA_SZ-1:LINE_OFS]));
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        flq_alloc_mm2 |-> !(&e_valid));

endmodule

// ==== hw/fillq_entry.sv ====
`timescale 1ns/1ps

module fillq_entry #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    parameter int  E_ID            = 0,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             alloc,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    alloc_addr,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] alloc_ld_id,
    input  logic                             mem_sel,
    input  logic                             mem_rsp_valid,
    input  logic [FLQ_ID_SZ-1:0]             mem_rsp_flq_id,
    input  logic                             pipe_gnt,
    input  logic                             done,
    output logic                             e_valid,
    output logic [l1_fill_pkg::PA_SZ-1:0]    e_addr,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] e_ld_id,
    output logic                             e_mem_req,
    output logic                             e_pipe_req
);

    import l1_fill_pkg::*;

    t_flq_state state;
    t_flq_state state_nxt;
    logic       replay_busy;
    logic       rsp_mat;

    assign rsp_mat = mem_rsp_valid && mem_rsp_flq_id == FLQ_ID_SZ'(E_ID);

    always_comb begin
        state_nxt = state;
        case (state)
            FLQ_IDLE:
                if (alloc) state_nxt = FLQ_MEM_REQ;
            FLQ_MEM_REQ:
                if (mem_sel) state_nxt = FLQ_MEM_WAIT;
            FLQ_MEM_WAIT:
                if (rsp_mat) state_nxt = FLQ_PIPE_REQ;
            FLQ_PIPE_REQ:
                if (done) state_nxt = FLQ_IDLE;
            default:
                state_nxt = FLQ_IDLE;
        endcase
    end

    // Granted replay waits here until mm2 retires it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FLQ_IDLE;
            replay_busy <= 1'b0;
        end else begin
            state <= state_nxt;
            if (done) begin
                replay_busy <= 1'b0;
            end else if (pipe_gnt) begin
                replay_busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_addr  <= alloc_addr;
            e_ld_id <= alloc_ld_id;
        end
    end

    assign e_valid    = state != FLQ_IDLE;
    assign e_mem_req  = state == FLQ_MEM_REQ;
    assign e_pipe_req = state == FLQ_PIPE_REQ && !replay_busy;

endmodule

// ==== hw/l1_fill_pkg.sv ====
package l1_fill_pkg;

    localparam int PA_SZ    = 32;
    localparam int LINE_OFS = 6;
    localparam int LD_ID_SZ = 4;

    // Source of a pipe packet
    typedef enum logic {
        ARB_LOAD,
        ARB_FILL
    } t_arb_type;

    // Outcome decided in mm2
    typedef enum logic [1:0] {
        ACT_HIT,
        ACT_MISS_ALLOC,
        ACT_RETRY,
        ACT_FILL
    } t_mempipe_action;

    typedef enum logic [1:0] {
        ST_HIT,
        ST_FILL,
        ST_RETRY
    } t_ld_status;

    // Fill queue entry lifetime
    typedef enum logic [1:0] {
        FLQ_IDLE,
        FLQ_MEM_REQ,
        FLQ_MEM_WAIT,
        FLQ_PIPE_REQ
    } t_flq_state;

endpackage

// ==== hw/l1_fill_top.sv ====
`timescale 1ns/1ps

module l1_fill_top #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    parameter int  L1_NUM_SETS     = 16,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ld_valid,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] ld_id,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    ld_addr,
    output logic                             ld_gnt,
    output logic                             rsp_valid,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] rsp_id,
    output logic [l1_fill_pkg::PA_SZ-1:0]    rsp_addr,
    output l1_fill_pkg::t_ld_status          rsp_status,
    output logic                             mem_req_valid,
    output logic [l1_fill_pkg::PA_SZ-1:0]    mem_req_addr,
    output logic [FLQ_ID_SZ-1:0]             mem_req_flq_id,
    input  logic                             mem_rsp_valid,
    input  logic [FLQ_ID_SZ-1:0]             mem_rsp_flq_id
);

    import l1_fill_pkg::*;

    // Replay request into mm0
    logic                 flq_pipe_req;
    logic [PA_SZ-1:0]     flq_pipe_addr;
    logic [FLQ_ID_SZ-1:0] flq_pipe_flq_id;
    logic [LD_ID_SZ-1:0]  flq_pipe_ld_id;
    logic                 flq_pipe_gnt;

    logic                 valid_mm1;
    t_arb_type            type_mm1;
    logic [LD_ID_SZ-1:0]  id_mm1;
    logic [PA_SZ-1:0]     addr_mm1;
    logic [FLQ_ID_SZ-1:0] flq_id_mm1;

    logic                 valid_mm2;
    t_arb_type            type_mm2;
    logic [LD_ID_SZ-1:0]  id_mm2;
    logic [PA_SZ-1:0]     addr_mm2;
    logic [FLQ_ID_SZ-1:0] flq_id_mm2;
    logic                 tag_hit_mm2;
    logic                 flq_addr_mat_mm2;
    logic                 flq_full_mm2;

    // mm2 side effects
    logic                 flq_alloc_mm2;
    logic [PA_SZ-1:0]     alloc_addr_mm2;
    logic [LD_ID_SZ-1:0]  alloc_ld_id_mm2;
    logic                 flq_done_mm2;
    logic [FLQ_ID_SZ-1:0] done_flq_id_mm2;
    logic                 tag_wr_mm2;
    logic [PA_SZ-1:0]     tag_wr_addr_mm2;

    mempipe_arb #(
        .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES)
    ) i_arb (.*);

    tag_lookup #(
        .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES),
        .L1_NUM_SETS     (L1_NUM_SETS)
    ) i_tag (.*);

    mempipe_resolve #(
        .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES)
    ) i_resolve (.*);

    fillq #(
        .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES),
        .L1_NUM_SETS     (L1_NUM_SETS)
    ) i_fillq (
        .pipe_addr_mm1 (addr_mm1),
        .*
    );

endmodule

// ==== hw/mempipe_arb.sv ====
`timescale 1ns/1ps

module mempipe_arb #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ld_valid,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] ld_id,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    ld_addr,
    output logic                             ld_gnt,
    input  logic                             flq_pipe_req,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    flq_pipe_addr,
    input  logic [FLQ_ID_SZ-1:0]             flq_pipe_flq_id,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] flq_pipe_ld_id,
    output logic                             flq_pipe_gnt,
    output logic                             valid_mm1,
    output l1_fill_pkg::t_arb_type           type_mm1,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] id_mm1,
    output logic [l1_fill_pkg::PA_SZ-1:0]    addr_mm1,
    output logic [FLQ_ID_SZ-1:0]             flq_id_mm1
);

    import l1_fill_pkg::*;

    // Replay has fixed priority over loads
    assign flq_pipe_gnt = flq_pipe_req;
    assign ld_gnt       = ld_valid & ~flq_pipe_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_mm1 <= 1'b0;
        end else begin
            valid_mm1 <= flq_pipe_req | ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (flq_pipe_req) begin
            type_mm1   <= ARB_FILL;
            id_mm1     <= flq_pipe_ld_id;
            addr_mm1   <= flq_pipe_addr;
            flq_id_mm1 <= flq_pipe_flq_id;
        end else begin
            type_mm1   <= ARB_LOAD;
            id_mm1     <= ld_id;
            addr_mm1   <= ld_addr;
            flq_id_mm1 <= '0;
        end
    end

endmodule

// ==== hw/mempipe_resolve.sv ====
`timescale 1ns/1ps

module mempipe_resolve #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_mm2,
    input  l1_fill_pkg::t_arb_type           type_mm2,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] id_mm2,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    addr_mm2,
    input  logic [FLQ_ID_SZ-1:0]             flq_id_mm2,
    input  logic                             tag_hit_mm2,
    input  logic                             flq_addr_mat_mm2,
    input  logic                             flq_full_mm2,
    output logic                             rsp_valid,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] rsp_id,
    output logic [l1_fill_pkg::PA_SZ-1:0]    rsp_addr,
    output l1_fill_pkg::t_ld_status          rsp_status,
    output logic                             flq_alloc_mm2,
    output logic [l1_fill_pkg::PA_SZ-1:0]    alloc_addr_mm2,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] alloc_ld_id_mm2,
    output logic                             flq_done_mm2,
    output logic [FLQ_ID_SZ-1:0]             done_flq_id_mm2,
    output logic                             tag_wr_mm2,
    output logic [l1_fill_pkg::PA_SZ-1:0]    tag_wr_addr_mm2
);

    import l1_fill_pkg::*;

    t_mempipe_action action_mm2;

    always_comb begin
        action_mm2 = ACT_MISS_ALLOC;
        if (type_mm2 == ARB_FILL) begin
            action_mm2 = ACT_FILL;
        end else if (tag_hit_mm2) begin
            action_mm2 = ACT_HIT;
        end else if (flq_addr_mat_mm2 || flq_full_mm2) begin
            // Set already pending or no free entry
            action_mm2 = ACT_RETRY;
        end
    end

    always_comb begin
        case (action_mm2)
            ACT_HIT:  rsp_status = ST_HIT;
            ACT_FILL: rsp_status = ST_FILL;
            default:  rsp_status = ST_RETRY;
        endcase
    end

    // Fill replay brings back the original load id
    assign rsp_valid = valid_mm2 && action_mm2 != ACT_MISS_ALLOC;
    assign rsp_id    = id_mm2;
    assign rsp_addr  = addr_mm2;

    assign flq_alloc_mm2   = valid_mm2 && action_mm2 == ACT_MISS_ALLOC;
    assign alloc_addr_mm2  = {addr_mm2[PA_SZ-1:LINE_OFS], {LINE_OFS{1'b0}}};
    assign alloc_ld_id_mm2 = id_mm2;

    assign flq_done_mm2    = valid_mm2 && action_mm2 == ACT_FILL;
    assign done_flq_id_mm2 = flq_id_mm2;
    assign tag_wr_mm2      = flq_done_mm2;
    assign tag_wr_addr_mm2 = addr_mm2;

    a_alloc_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(flq_alloc_mm2 && flq_done_mm2));

endmodule

// ==== hw/tag_lookup.sv ====
`timescale 1ns/1ps

module tag_lookup #(
    parameter int  FLQ_NUM_ENTRIES = 4,
    parameter int  L1_NUM_SETS     = 16,
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_mm1,
    input  l1_fill_pkg::t_arb_type           type_mm1,
    input  logic [l1_fill_pkg::LD_ID_SZ-1:0] id_mm1,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    addr_mm1,
    input  logic [FLQ_ID_SZ-1:0]             flq_id_mm1,
    input  logic                             tag_wr_mm2,
    input  logic [l1_fill_pkg::PA_SZ-1:0]    tag_wr_addr_mm2,
    output logic                             valid_mm2,
    output l1_fill_pkg::t_arb_type           type_mm2,
    output logic [l1_fill_pkg::LD_ID_SZ-1:0] id_mm2,
    output logic [l1_fill_pkg::PA_SZ-1:0]    addr_mm2,
    output logic [FLQ_ID_SZ-1:0]             flq_id_mm2,
    output logic                             tag_hit_mm2
);

    import l1_fill_pkg::*;

    localparam int SET_SZ = $clog2(L1_NUM_SETS);
    localparam int TAG_LO = LINE_OFS + SET_SZ;

    logic [L1_NUM_SETS-1:0] tag_valid;
    logic [PA_SZ-1:TAG_LO]  tag_arr [L1_NUM_SETS];
    logic [SET_SZ-1:0]      set_mm1;
    logic [SET_SZ-1:0]      wr_set;
    logic                   hit_mm1;

    assign set_mm1 = addr_mm1[TAG_LO-1:LINE_OFS];
    assign wr_set  = tag_wr_addr_mm2[TAG_LO-1:LINE_OFS];
    assign hit_mm1 = tag_valid[set_mm1] && tag_arr[set_mm1] == addr_mm1[PA_SZ-1:TAG_LO];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= '0;
            valid_mm2 <= 1'b0;
        end else begin
            valid_mm2 <= valid_mm1;
            if (tag_wr_mm2) tag_valid[wr_set] <= 1'b1;
        end
    end

    // Fill replaces whatever line held the set
    always_ff @(posedge clk) begin
        if (tag_wr_mm2) tag_arr[wr_set] <= tag_wr_addr_mm2[PA_SZ-1:TAG_LO];
        type_mm2    <= type_mm1;
        id_mm2      <= id_mm1;
        addr_mm2    <= addr_mm1;
        flq_id_mm2  <= flq_id_mm1;
        tag_hit_mm2 <= hit_mm1;
    end

    a_tag_wr_valid: assert property (@(posedge clk) disable iff (!rst_n)
        tag_wr_mm2 |-> valid_mm2 && type_mm2 == ARB_FILL);

endmodule

// ==== project.f ====
hw/l1_fill_pkg.sv
hw/mempipe_arb.sv
hw/tag_lookup.sv
hw/mempipe_resolve.sv
hw/fillq_entry.sv
hw/fillq.sv
hw/l1_fill_top.sv
sim/tb_l1_fill.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module tb_l1_fill -o tb_l1_fill \
    && ./obj_dir/tb_l1_fill | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "Finished with no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== sim/tb_l1_fill.sv ====
`timescale 1ns/1ps

module tb_l1_fill;

    import l1_fill_pkg::*;

    localparam int FLQ_NUM_ENTRIES = 4;
    localparam int L1_NUM_SETS     = 16;
    localparam int FLQ_ID_SZ       = $clog2(FLQ_NUM_ENTRIES);
    localparam int MEM_LAT         = 20;
    localparam int N_ROWS          = 11;
    localparam int WD_CYCLES       = N_ROWS * (MEM_LAT + 20) + 100;

    logic                 clk;
    logic                 rst_n;
    logic                 ld_valid;
    logic [LD_ID_SZ-1:0]  ld_id;
    logic [PA_SZ-1:0]     ld_addr;
    logic                 ld_gnt;
    logic                 rsp_valid;
    logic [LD_ID_SZ-1:0]  rsp_id;
    logic [PA_SZ-1:0]     rsp_addr;
    t_ld_status           rsp_status;
    logic                 mem_req_valid;
    logic [PA_SZ-1:0]     mem_req_addr;
    logic [FLQ_ID_SZ-1:0] mem_req_flq_id;
    logic                 mem_rsp_valid;
    logic [FLQ_ID_SZ-1:0] mem_rsp_flq_id;

    // Set is addr[9:6], tag is addr[31:10]
    logic [LD_ID_SZ-1:0] row_id [N_ROWS] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5,
                                             4'd6, 4'd7, 4'd8, 4'd9, 4'd10};
    logic [PA_SZ-1:0] row_line [N_ROWS] = '{32'h0004_0040, 32'h0004_0040, 32'h0008_0080,
                                            32'h000c_0080, 32'h000c_0080, 32'h0008_0080,
                                            32'h0010_0100, 32'h0010_0140, 32'h0010_0180,
                                            32'h0010_01c0, 32'h0010_0200};
    t_ld_status row_st [N_ROWS] = '{ST_FILL, ST_HIT, ST_FILL, ST_RETRY, ST_FILL, ST_FILL,
                                    ST_FILL, ST_FILL, ST_FILL, ST_FILL, ST_RETRY};
    // Drain every response up to this row before going on
    logic row_wait [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1,
                                1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic [PA_SZ-1:0]     row_addr [N_ROWS];
    int                   row_gnt [N_ROWS];
    int                   rsp_cnt [N_ROWS];
    int                   mem_cnt [N_ROWS];
    int                   row_flq [N_ROWS];
    logic [FLQ_NUM_ENTRIES-1:0] flq_busy;
    int                   cur_row;
    int                   cyc;
    int                   mism_cnt;
    int                   fail_cnt;
    int                   mem_due [$];
    logic [FLQ_ID_SZ-1:0] mem_id_q [$];

    l1_fill_top #(
        .FLQ_NUM_ENTRIES (FLQ_NUM_ENTRIES),
        .L1_NUM_SETS     (L1_NUM_SETS)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic check_outputs_idle();
        check_val("ld_gnt", int'(ld_gnt), 0);
        check_val("rsp_valid", int'(rsp_valid), 0);
        check_val("mem_req_valid", int'(mem_req_valid), 0);
    endtask

    function automatic int row_of_id(input logic [LD_ID_SZ-1:0] id);
        for (int r = 0; r < N_ROWS; r++) begin
            if (row_id[r] == id) begin
                return r;
            end
        end
        return -1;
    endfunction

    // Allocation takes the lowest entry not holding a fill
    function automatic int lowest_free_entry();
        for (int e = 0; e < FLQ_NUM_ENTRIES; e++) begin
            if (!flq_busy[e]) begin
                return e;
            end
        end
        return -1;
    endfunction

    function automatic bit rows_done(input int last);
        for (int r = 0; r <= last; r++) begin
            if (rsp_cnt[r] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Hold the load until it is granted
    task automatic issue_load(input int r);
        cur_row  = r;
        ld_valid = 1'b1;
        ld_id    = row_id[r];
        ld_addr  = row_addr[r];
        @(posedge clk);
        while (!ld_gnt) begin
            @(posedge clk);
        end
        #10;
        ld_valid = 1'b0;
    endtask

    // Grants, memory requests and responses
    always @(posedge clk) begin
        int r;
        bit found;
        if (rst_n) begin
            if (ld_valid && ld_gnt) row_gnt[cur_row] = cyc;
            // Requests before responses, an entry retiring now was held at allocation
            if (mem_req_valid) begin
                found = 1'b0;
                for (int i = 0; i < N_ROWS; i++) begin
                    if (!found && row_st[i] == ST_FILL && row_gnt[i] >= 0 &&
                        mem_cnt[i] == 0 && row_line[i] == mem_req_addr) begin
                        mem_cnt[i]++;
                        check_val($sformatf("row %0d mem_req_flq_id", i),
                                  int'(mem_req_flq_id), lowest_free_entry());
                        flq_busy[mem_req_flq_id] = 1'b1;
                        row_flq[i] = int'(mem_req_flq_id);
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    $display("unexpected memory request at %0t for %h", $time, mem_req_addr);
                    fail_cnt++;
                end
            end
            if (rsp_valid) begin
                r = row_of_id(rsp_id);
                if (r < 0 || row_gnt[r] < 0) begin
                    $display("response at %0t for id %0d that was never granted", $time, rsp_id);
                    fail_cnt++;
                end else begin
                    rsp_cnt[r]++;
                    if (row_flq[r] >= 0) begin
                        flq_busy[row_flq[r]] = 1'b0;
                    end
                    check_val($sformatf("row %0d status", r), int'(rsp_status), int'(row_st[r]));
                    if (row_st[r] == ST_FILL) begin
                        check_val($sformatf("row %0d fill addr", r), int'(rsp_addr),
                                  int'(row_line[r]));
                        if (cyc - row_gnt[r] <= MEM_LAT) begin
                            $display("fill for row %0d came back before the memory answered", r);
                            fail_cnt++;
                        end
                    end else begin
                        check_val($sformatf("row %0d addr", r), int'(rsp_addr), int'(row_addr[r]));
                        check_val($sformatf("row %0d latency", r), cyc - row_gnt[r], 2);
                    end
                end
            end
        end
    end

    // Pipelined memory with fixed latency
    initial begin
        mem_rsp_valid  = 1'b0;
        mem_rsp_flq_id = '0;
        forever begin
            @(posedge clk);
            if (mem_req_valid) begin
                mem_due.push_back(cyc + MEM_LAT);
                mem_id_q.push_back(mem_req_flq_id);
            end
            #10;
            mem_rsp_valid = 1'b0;
            if (mem_due.size() > 0 && mem_due[0] <= cyc) begin
                mem_rsp_valid  = 1'b1;
                mem_rsp_flq_id = mem_id_q.pop_front();
                void'(mem_due.pop_front());
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with responses still missing", WD_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [LINE_OFS-1:0] ofs;
        rst_n    = 1'b0;
        ld_valid = 1'b0;
        ld_id    = '0;
        ld_addr  = '0;
        cur_row  = 0;
        cyc      = 0;
        mism_cnt = 0;
        fail_cnt = 0;
        flq_busy = '0;
        void'($urandom(32'hce1e_df76));
        for (int r = 0; r < N_ROWS; r++) begin
            row_gnt[r] = -1;
            rsp_cnt[r] = 0;
            mem_cnt[r] = 0;
            row_flq[r] = -1;
        end

        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            check_outputs_idle();
        end
        #10;
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_outputs_idle();
        end
        #10;

        for (int r = 0; r < N_ROWS; r++) begin
            ofs = LINE_OFS'($urandom);
            row_addr[r] = {row_line[r][PA_SZ-1:LINE_OFS], ofs};
            issue_load(r);
            if (row_wait[r]) begin
                while (!rows_done(r)) begin
                    @(posedge clk);
                    #10;
                end
            end
        end

        // Catch late extra responses or requests
        repeat (MEM_LAT + 10) @(posedge clk);
        for (int r = 0; r < N_ROWS; r++) begin
            if (rsp_cnt[r] != 1) begin
                $display("row %0d received %0d responses instead of one", r, rsp_cnt[r]);
                fail_cnt++;
            end
            if (row_st[r] == ST_FILL && mem_cnt[r] != 1) begin
                $display("row %0d never sent its memory request", r);
                fail_cnt++;
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
